// ==== logic/frontend_settings.svh ====
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// log2 of the number of instruction queue entries
// a value of 4 gives a sixteen entry ring
`define FE_QUEUE_DEPTH_BITS 4

// address of the first instruction fetched after reset
// the PC walks upward from here in steps of 4
`define FE_RESET_PC 32'h0000_1000

// width of the AXI4-Lite read address
// the PC registers and the address typedef follow it
`define FE_ADDR_WIDTH 32

`endif

// ==== logic/frontend_pkg.sv ====
`default_nettype none
`include "frontend_settings.svh"

package frontend_pkg;

  // raw 32-bit RV32I instruction word as read from memory
  typedef logic [31:0] instr_t;

  // program-order tag, counts every fetched instruction from 0
  typedef logic [63:0] order_t;

  // generic data word, used for immediates and PC values
  typedef logic [31:0] word_t;

  // byte address on the instruction memory port
  typedef logic [`FE_ADDR_WIDTH-1:0] addr_t;

  // architectural register index, x0 to x31
  typedef logic [4:0] reg_idx_t;

  // major opcode in bits 6:0 of the word
  typedef logic [6:0] opcode_t;

  // major opcodes that carry an immediate
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_JAL    = 7'b1101111;

  // the only read response that lets fetching go on
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // fetch FSM, fault is sticky until reset
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_ADDR,
    FETCH_DATA,
    FETCH_FAULT
  } fetch_state_t;

  // AXI4-Lite read address channel payload
  typedef struct packed {
    addr_t      araddr;
    logic [2:0] arprot;
  } axil_ar_t;

  // AXI4-Lite read data channel payload
  typedef struct packed {
    word_t      rdata;
    logic [1:0] rresp;
  } axil_r_t;

  // what fetch pushes into the queue
  typedef struct packed {
    instr_t instr;
    order_t order;
  } fetch_entry_t;

  // fully decoded instruction handed to rename/issue
  typedef struct packed {
    order_t     order;
    instr_t     instr;
    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
  } decoded_instr_t;

endpackage

`default_nettype wire

// ==== logic/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode (
  input  frontend_pkg::fetch_entry_t   entry,
  output frontend_pkg::decoded_instr_t dec
);

  frontend_pkg::instr_t w;

  // one candidate immediate per encoding format
  frontend_pkg::word_t imm_i;
  frontend_pkg::word_t imm_s;
  frontend_pkg::word_t imm_b;
  frontend_pkg::word_t imm_u;
  frontend_pkg::word_t imm_j;

  assign w = entry.instr;

  // order and the raw word travel with the decoded fields
  assign dec.order = entry.order;
  assign dec.instr = w;

  // register and function fields sit at fixed positions in every format,
  // so they are sliced out unconditionally
  assign dec.opcode = w[6:0];
  assign dec.rd     = w[11:7];
  assign dec.funct3 = w[14:12];
  assign dec.rs1    = w[19:15];
  assign dec.rs2    = w[24:20];
  assign dec.funct7 = w[31:25];

  // all immediates sign extend from bit 31
  assign imm_i = {{20{w[31]}}, w[31:20]};
  assign imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
  // branch and jump offsets are in halfwords, bit 0 is always zero
  assign imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  assign imm_u = {w[31:12], 12'b0};
  assign imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

  // pick the immediate by opcode class
  always_comb begin
    case (w[6:0])
      frontend_pkg::OPC_LOAD,
      frontend_pkg::OPC_OP_IMM,
      frontend_pkg::OPC_JALR: begin
        dec.imm = imm_i;
      end
      frontend_pkg::OPC_STORE: begin
        dec.imm = imm_s;
      end
      frontend_pkg::OPC_BRANCH: begin
        dec.imm = imm_b;
      end
      frontend_pkg::OPC_LUI,
      frontend_pkg::OPC_AUIPC: begin
        dec.imm = imm_u;
      end
      frontend_pkg::OPC_JAL: begin
        dec.imm = imm_j;
      end
      default: begin
        // R-type, fences and system calls have no immediate here
        dec.imm = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "frontend_settings.svh"

module fetch_unit (
  input  logic                       clk,
  input  logic                       rst,
  // AXI4-Lite read address channel
  output logic                       arvalid,
  input  logic                       arready,
  output frontend_pkg::axil_ar_t     ar,
  // AXI4-Lite read data channel
  input  logic                       rvalid,
  output logic                       rready,
  input  frontend_pkg::axil_r_t      r,
  // push side of the instruction queue
  input  logic                       full,
  output logic                       push,
  output frontend_pkg::fetch_entry_t entry,
  output logic                       fault
);

  frontend_pkg::fetch_state_t state;
  frontend_pkg::addr_t        pc;
  frontend_pkg::order_t       order;

  // the response is OKAY and can go into the queue
  logic resp_ok;

  // arvalid comes straight from the state, so it cannot glitch
  // and stays up until the address is taken
  assign arvalid = (state == frontend_pkg::FETCH_ADDR);
  // a slot was reserved before the request, so the data is always accepted
  assign rready  = (state == frontend_pkg::FETCH_DATA);
  assign fault   = (state == frontend_pkg::FETCH_FAULT);

  // unprivileged, secure, instruction access
  assign ar.araddr = pc;
  assign ar.arprot = 3'b100;

  assign resp_ok = (r.rresp == frontend_pkg::AXI_RESP_OKAY);

  // push on the R handshake itself, the word goes in with the current order
  assign push        = rready && rvalid && resp_ok;
  assign entry.instr = r.rdata;
  assign entry.order = order;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= frontend_pkg::FETCH_IDLE;
      pc    <= `FE_RESET_PC;
      order <= '0;
    end else begin
      case (state)
        frontend_pkg::FETCH_IDLE: begin
          // only one read is ever in flight, so a free slot seen here
          // is still free when the response comes back
          if (!full) begin
            state <= frontend_pkg::FETCH_ADDR;
          end
        end
        frontend_pkg::FETCH_ADDR: begin
          if (arready) begin
            state <= frontend_pkg::FETCH_DATA;
          end
        end
        frontend_pkg::FETCH_DATA: begin
          if (rvalid) begin
            if (resp_ok) begin
              // sequential fetch only, no redirects in this front end
              pc    <= pc + 4;
              order <= order + 1'b1;
              state <= frontend_pkg::FETCH_IDLE;
            end else begin
              state <= frontend_pkg::FETCH_FAULT;
            end
          end
        end
        frontend_pkg::FETCH_FAULT: begin
          // stay here until reset, nothing more is fetched
          state <= frontend_pkg::FETCH_FAULT;
        end
      endcase
    end
  end

  // the request must not move while the memory has not taken it
  assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(ar))
    else $error("read address changed or dropped before arready");

  // the slot reserved before the request must still be free
  assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("fetch pushed into a full instruction queue");

endmodule

`default_nettype wire

// ==== logic/instruction_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_queue #(
  parameter int DEPTH_BITS = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  // push side, driven by fetch
  input  logic                         push,
  input  frontend_pkg::fetch_entry_t   entry,
  output logic                         full,
  // pop side, driven by dispatch
  input  logic                         pop,
  output logic                         head_valid,
  output frontend_pkg::decoded_instr_t head
);

  localparam int NUM_ENTRIES = 2 ** DEPTH_BITS;

  // wr_ptr is where the next push lands, rd_ptr points at the oldest entry
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;

  // payload storage and one valid bit per slot
  frontend_pkg::fetch_entry_t mem [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0]     valid;

  // the oldest entry, fed to the decoder
  frontend_pkg::fetch_entry_t oldest;

  // the ring is full exactly when the slot to be written still holds
  // an entry, which avoids a separate counter
  assign full       = valid[wr_ptr];
  assign head_valid = valid[rd_ptr];
  assign oldest     = mem[rd_ptr];

  // control state with reset
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      valid  <= '0;
    end else begin
      // push and pop may both happen in one cycle but never on the same
      // slot, since an empty head blocks pop and a full tail blocks push
      if (pop) begin
        valid[rd_ptr] <= 1'b0;
        rd_ptr        <= rd_ptr + 1'b1;
      end
      if (push) begin
        valid[wr_ptr] <= 1'b1;
        wr_ptr        <= wr_ptr + 1'b1;
      end
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= entry;
    end
  end

  // decode sits on the read side, so dispatch sees a decoded head
  decode u_decode (
    .entry (oldest),
    .dec   (head)
  );

  // dispatch only takes what is there
  assert property (@(posedge clk) disable iff (rst) pop |-> head_valid)
    else $error("pop from an empty queue slot");

  // fetch must respect full
  assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("push into a full queue slot");

endmodule

`default_nettype wire

// ==== logic/dispatch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage (
  input  logic                         clk,
  input  logic                         rst,
  // queue side
  input  logic                         head_valid,
  input  frontend_pkg::decoded_instr_t head,
  output logic                         pop,
  // rename/issue side
  output logic                         out_valid,
  output frontend_pkg::decoded_instr_t out,
  input  logic                         out_ready
);

  // the register can take a new entry when it is empty
  // or its current entry leaves in this cycle
  logic slot_free;

  assign slot_free = !out_valid || out_ready;
  assign pop       = head_valid && slot_free;

  // occupancy of the output register
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (pop) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      // handshake with nothing behind it empties the register
      out_valid <= 1'b0;
    end
  end

  // payload register, only loads on a pop
  always_ff @(posedge clk) begin
    if (pop) begin
      out <= head;
    end
  end

  // under back-pressure the consumer must see the same instruction
  // until it takes it
  assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out))
    else $error("dispatch output changed while stalled");

endmodule

`default_nettype wire

// ==== logic/rv_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "frontend_settings.svh"

module rv_frontend (
  input  logic                         clk,
  input  logic                         rst,
  // instruction memory, AXI4-Lite read only
  output logic                         arvalid,
  input  logic                         arready,
  output frontend_pkg::axil_ar_t       ar,
  input  logic                         rvalid,
  output logic                         rready,
  input  frontend_pkg::axil_r_t        r,
  // decoded instruction stream to rename/issue
  output logic                         out_valid,
  output frontend_pkg::decoded_instr_t out,
  input  logic                         out_ready,
  // sticky, set by an error response
  output logic                         fault
);

  // fetch to queue
  logic                       push;
  frontend_pkg::fetch_entry_t entry;
  logic                       full;

  // queue to dispatch
  logic                         pop;
  logic                         head_valid;
  frontend_pkg::decoded_instr_t head;

  fetch_unit u_fetch (
    .clk     (clk),
    .rst     (rst),
    .arvalid (arvalid),
    .arready (arready),
    .ar      (ar),
    .rvalid  (rvalid),
    .rready  (rready),
    .r       (r),
    .full    (full),
    .push    (push),
    .entry   (entry),
    .fault   (fault)
  );

  instruction_queue #(
    .DEPTH_BITS (`FE_QUEUE_DEPTH_BITS)
  ) u_queue (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .entry      (entry),
    .full       (full),
    .pop        (pop),
    .head_valid (head_valid),
    .head       (head)
  );

  dispatch_stage u_dispatch (
    .clk        (clk),
    .rst        (rst),
    .head_valid (head_valid),
    .head       (head),
    .pop        (pop),
    .out_valid  (out_valid),
    .out        (out),
    .out_ready  (out_ready)
  );

endmodule

`default_nettype wire

// ==== test/axil_imem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_imem_model #(
  parameter int SEED = 1
) (
  input  logic                   clk,
  input  logic                   rst,
  // read address channel
  input  logic                   arvalid,
  output logic                   arready,
  input  frontend_pkg::axil_ar_t ar,
  // read data channel
  output logic                   rvalid,
  input  logic                   rready,
  output frontend_pkg::axil_r_t  r,
  // reads of this address answer with SLVERR
  input  frontend_pkg::addr_t    err_addr
);

  // instruction image, filled by the testbench before the first read
  frontend_pkg::word_t words [frontend_pkg::addr_t];

  integer seed = SEED;

  // cycles left before arready or rvalid goes up
  int ar_wait;
  int r_wait;

  // a read was accepted and its response is not done yet
  logic                busy;
  frontend_pkg::addr_t rd_addr;

  // latency of 0 to 5 extra cycles
  function automatic int next_delay();
    logic [31:0] rnd;
    rnd = $random(seed);
    return int'(rnd[30:0] % 31'd6);
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      r       <= '0;
      busy    <= 1'b0;
      rd_addr <= '0;
      ar_wait <= next_delay();
      r_wait  <= 0;
    end else begin
      if (arvalid && arready) begin
        // address taken, start counting down the data latency
        arready <= 1'b0;
        busy    <= 1'b1;
        rd_addr <= ar.araddr;
        r_wait  <= next_delay();
      end else if (arvalid && !busy) begin
        if (ar_wait == 0) begin
          arready <= 1'b1;
        end else begin
          ar_wait <= ar_wait - 1;
        end
      end
      if (busy && !rvalid) begin
        if (r_wait == 0) begin
          rvalid <= 1'b1;
          if (rd_addr == err_addr) begin
            r.rdata <= '0;
            r.rresp <= 2'b10;
          end else if (words.exists(rd_addr)) begin
            r.rdata <= words[rd_addr];
            r.rresp <= 2'b00;
          end else begin
            // nothing mapped here, answer DECERR
            r.rdata <= '0;
            r.rresp <= 2'b11;
          end
        end else begin
          r_wait <= r_wait - 1;
        end
      end
      if (rvalid && rready) begin
        rvalid  <= 1'b0;
        busy    <= 1'b0;
        ar_wait <= next_delay();
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/rv_frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "frontend_settings.svh"

module rv_frontend_tb;

  // instructions before the faulting address
  localparam int ERR_ORDER = 340;
  localparam frontend_pkg::addr_t ERR_ADDR = `FE_RESET_PC + 32'(4 * ERR_ORDER);
  // queue entries plus the dispatch register
  localparam int DEPTH    = 1 << `FE_QUEUE_DEPTH_BITS;
  localparam int CAPACITY = DEPTH + 1;
  localparam int STREAM_TIMEOUT = 100000;
  localparam int FAULT_TIMEOUT  = 2000;
  localparam int QUIET_CYCLES   = 500;

  logic                         clk;
  logic                         rst;
  logic                         arvalid;
  logic                         arready;
  frontend_pkg::axil_ar_t       ar;
  logic                         rvalid;
  logic                         rready;
  frontend_pkg::axil_r_t        r;
  logic                         out_valid;
  frontend_pkg::decoded_instr_t out;
  logic                         out_ready;
  logic                         fault;

  integer seed;
  // expected memory image by byte address
  frontend_pkg::word_t exp_words [frontend_pkg::addr_t];

  // scoreboard state, updated by the monitor once per cycle
  frontend_pkg::addr_t          exp_addr;
  int                           ar_count;
  int                           ok_count;
  int                           disp_count;
  int                           outstanding;
  int                           max_held;
  logic                         ar_pending;
  frontend_pkg::axil_ar_t       last_ar;
  logic                         out_stalled;
  frontend_pkg::decoded_instr_t last_out;
  int                           stall_left;

  rv_frontend u_dut (
    .clk       (clk),
    .rst       (rst),
    .arvalid   (arvalid),
    .arready   (arready),
    .ar        (ar),
    .rvalid    (rvalid),
    .rready    (rready),
    .r         (r),
    .out_valid (out_valid),
    .out       (out),
    .out_ready (out_ready),
    .fault     (fault)
  );

  axil_imem_model #(
    .SEED (32'h2083dfc3)
  ) u_mem (
    .clk      (clk),
    .rst      (rst),
    .arvalid  (arvalid),
    .arready  (arready),
    .ar       (ar),
    .rvalid   (rvalid),
    .rready   (rready),
    .r        (r),
    .err_addr (ERR_ADDR)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "testbench stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("Mismatch in %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  function automatic frontend_pkg::addr_t word_addr(input int ord);
    return `FE_RESET_PC + 32'(4 * ord);
  endfunction

  // random word, mostly with a real RV32I major opcode
  function automatic frontend_pkg::word_t make_word();
    logic [31:0] raw;
    logic [31:0] sel;
    logic [6:0]  opc;
    raw = $random(seed);
    sel = $random(seed);
    case (sel[3:0])
      4'd0:    opc = 7'b0000011;
      4'd1:    opc = 7'b0010011;
      4'd2:    opc = 7'b0010111;
      4'd3:    opc = 7'b0100011;
      4'd4:    opc = 7'b0110111;
      4'd5:    opc = 7'b1100011;
      4'd6:    opc = 7'b1100111;
      4'd7:    opc = 7'b1101111;
      4'd8:    opc = 7'b0110011;
      4'd9:    opc = 7'b0001111;
      4'd10:   opc = 7'b1110011;
      default: opc = raw[6:0];
    endcase
    return {raw[31:7], opc};
  endfunction

  // RV32I field split and immediate selection, worked from the ISA formats
  function automatic frontend_pkg::decoded_instr_t ref_decode(input logic [63:0] ord,
                                                              input logic [31:0] w);
    frontend_pkg::decoded_instr_t d;
    logic signed [31:0]           sw;
    logic [31:0]                  s_high;
    logic [12:0]                  boff;
    logic [20:0]                  joff;
    sw       = w;
    // upper store offset bits, sign extended from bit 31
    s_high   = sw >>> 25;
    boff     = {w[31], w[7], w[30:25], w[11:8], 1'b0};
    joff     = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    d.order  = ord;
    d.instr  = w;
    d.opcode = w[6:0];
    d.rd     = w[11:7];
    d.funct3 = w[14:12];
    d.rs1    = w[19:15];
    d.rs2    = w[24:20];
    d.funct7 = w[31:25];
    case (w[6:0])
      7'b0000011, 7'b0010011, 7'b1100111: d.imm = sw >>> 20;
      7'b0100011: d.imm = (s_high << 5) | {27'b0, w[11:7]};
      7'b1100011: d.imm = {{19{boff[12]}}, boff};
      7'b0110111, 7'b0010111: d.imm = w & 32'hffff_f000;
      7'b1101111: d.imm = {{11{joff[20]}}, joff};
      default: d.imm = '0;
    endcase
    return d;
  endfunction

  // consumer back-pressure, with an occasional stall far longer than the queue
  initial begin
    logic [31:0] rnd;
    stall_left = 0;
    forever begin
      @(posedge clk);
      #1;
      rnd = $random(seed);
      if (stall_left > 0) begin
        out_ready  = 1'b0;
        stall_left = stall_left - 1;
      end else if (rnd[15:8] == 8'd0) begin
        out_ready  = 1'b0;
        stall_left = 200 + int'(rnd[22:16]);
      end else begin
        out_ready = rnd[0] | rnd[1];
      end
    end
  end

  // inputs are stable at the falling edge, so every check reads settled values
  always @(negedge clk) begin
    frontend_pkg::decoded_instr_t d;
    int held;
    if (!rst) begin
      held = ok_count - disp_count;
      // rready is up exactly while the single read waits for its data
      check_value("rready while a read is outstanding", 64'(outstanding), 64'(rready));
      if (ar_pending) begin
        check_value("arvalid held until arready", 64'(1), 64'(arvalid));
        check_value("ar held until arready", 64'(last_ar), 64'(ar));
      end
      if (arvalid && arready) begin
        check_value("read address", 64'(exp_addr), 64'(ar.araddr));
        check_value("read marked as instruction fetch", 64'(1), 64'(ar.arprot[2]));
        check_value("reads outstanding", 64'(0), 64'(outstanding));
        // queue occupancy alone, without the dispatch register
        check_value("read while queue full", 64'(1),
                    64'((held - int'(out_valid)) < DEPTH));
        outstanding = 1;
        exp_addr    = exp_addr + 32'd4;
        ar_count    = ar_count + 1;
      end
      if (rvalid && rready) begin
        outstanding = 0;
        if (r.rresp == 2'b00) begin
          ok_count = ok_count + 1;
        end
      end
      if (out_stalled) begin
        check_value("out_valid held while stalled", 64'(1), 64'(out_valid));
        check_value("order held while stalled", last_out.order, out.order);
        check_value("word held while stalled", 64'(last_out.instr), 64'(out.instr));
        check_value("imm held while stalled", 64'(last_out.imm), 64'(out.imm));
        check_value("fields held while stalled",
                    64'({last_out.opcode, last_out.funct3, last_out.funct7,
                         last_out.rs1, last_out.rs2, last_out.rd}),
                    64'({out.opcode, out.funct3, out.funct7,
                         out.rs1, out.rs2, out.rd}));
      end
      if (out_valid && out_ready) begin
        check_value("dispatch before error address", 64'(1), 64'(disp_count < ERR_ORDER));
        d = ref_decode(64'(disp_count), exp_words[word_addr(disp_count)]);
        check_value("order", d.order, out.order);
        check_value("instr", 64'(d.instr), 64'(out.instr));
        check_value("opcode", 64'(d.opcode), 64'(out.opcode));
        check_value("funct3", 64'(d.funct3), 64'(out.funct3));
        check_value("funct7", 64'(d.funct7), 64'(out.funct7));
        check_value("rs1", 64'(d.rs1), 64'(out.rs1));
        check_value("rs2", 64'(d.rs2), 64'(out.rs2));
        check_value("rd", 64'(d.rd), 64'(out.rd));
        check_value("imm", 64'(d.imm), 64'(out.imm));
        disp_count = disp_count + 1;
      end
      held = ok_count - disp_count;
      check_value("instructions held in front end", 64'(1), 64'(held <= CAPACITY));
      if (held > max_held) begin
        max_held = held;
      end
      out_stalled = out_valid && !out_ready;
      last_out    = out;
      ar_pending  = arvalid && !arready;
      last_ar     = ar;
    end
  end

  initial begin
    int cycles;
    frontend_pkg::word_t w;
    seed        = 32'h2083dfc3;
    rst         = 1'b1;
    out_ready   = 1'b0;
    exp_addr    = `FE_RESET_PC;
    ar_count    = 0;
    ok_count    = 0;
    disp_count  = 0;
    outstanding = 0;
    max_held    = 0;
    ar_pending  = 1'b0;
    out_stalled = 1'b0;
    last_ar     = '0;
    last_out    = '0;

    // the image covers the faulting address too, its word is never returned
    for (int i = 0; i <= ERR_ORDER; i++) begin
      w = make_word();
      exp_words[word_addr(i)] = w;
      u_mem.words[word_addr(i)] = w;
    end

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("arvalid after reset", 64'(0), 64'(arvalid));
    check_value("out_valid after reset", 64'(0), 64'(out_valid));
    check_value("fault after reset", 64'(0), 64'(fault));

    cycles = 0;
    while (!fault) begin
      @(posedge clk);
      cycles = cycles + 1;
      if (cycles > STREAM_TIMEOUT) begin
        abort_run("fault never rose after the error response");
      end
    end
    check_value("reads accepted up to the fault", 64'(ERR_ORDER + 1), 64'(ar_count));

    cycles = 0;
    while (disp_count < ERR_ORDER) begin
      @(posedge clk);
      cycles = cycles + 1;
      if (cycles > FAULT_TIMEOUT) begin
        abort_run("instructions before the error address were not all dispatched");
      end
    end

    // with fault set nothing more may be read or dispatched
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(posedge clk);
    end
    check_value("reads after fault", 64'(ERR_ORDER + 1), 64'(ar_count));
    check_value("dispatched count", 64'(ERR_ORDER), 64'(disp_count));
    check_value("queue filled under back-pressure", 64'(CAPACITY), 64'(max_held));

    if (fault && disp_count == ERR_ORDER && !out_valid) begin
      $display("** PASS **");
    end else begin
      abort_run("front end did not settle after the fault");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_frontend.f ====
+incdir+logic
logic/frontend_pkg.sv
logic/decode.sv
logic/fetch_unit.sv
logic/instruction_queue.sv
logic/dispatch_stage.sv
logic/rv_frontend.sv
test/axil_imem_model.sv
test/rv_frontend_tb.sv

// ==== build.sh ====
#!/bin/sh
# compile the rv_frontend testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module rv_frontend_tb -f rv_frontend.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vrv_frontend_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx '\*\* PASS \*\*'; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
